/* build.f */
hdl/sdmacPkg.sv
hdl/dmaRegs.sv
hdl/wordFifo.sv
hdl/scsiPacker.sv
hdl/sdmacDatapath.sv
tests/sdmacTb.sv

/* Makefile */
# Verilator build and run of the SCSI DMA data path testbench

VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := sdmacTb
FILELIST  := build.f
OBJDIR    := obj_dir

.PHONY: simulate clean

# The binary exits with a failing status when the testbench stops on an error
simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* tests/sdmacStim.txt */
# W addr data wstrb resp | R addr data resp | S half in | E half out | N pdInReady
# I idle cycles; all fields hex, resp 0 is OKAY and 2 is SLVERR
# Reset values and unknown offsets
R 0 00000000 0
R C 00000000 0
R 4 00000001 0
W 2 12345678 F 2
R 6 00000000 2
# CPU to SCSI, high half first, then low half first
W 0 00000004 F 0
W 8 A1B2C3D4 F 0
W 8 11223344 F 0
E A1B2
E C3D4
E 1122
E 3344
R C 00000002 0
W 0 00000006 F 0
W 8 CAFEBABE F 0
E BABE
E CAFE
R C 00000003 0
# SCSI to CPU with the level in STATUS
W 0 00000005 F 0
S 1111
S 2222
S 3333
S 4444
R 4 00000200 0
R 8 11112222 0
R 4 00000100 0
R 8 33334444 0
W 0 00000007 F 0
S 5555
S 6666
I 2
R 8 66665555 0
R 4 00000001 0
R C 00000006 0
# Empty read, partial strobe and overfill
R 8 00000000 2
W 0 00000000 F 0
W 8 DEADBEEF 3 2
W 8 00000001 F 0
W 8 00000002 F 0
W 8 00000003 F 0
W 8 00000004 F 0
W 8 00000005 F 0
W 8 00000006 F 0
W 8 00000007 F 0
W 8 00000008 F 0
W 8 00000009 F 2
R 4 00000802 0
R 8 00000000 2
# Flush empties the FIFO and clears control
W 0 00000008 F 0
R 4 00000001 0
R 0 00000000 0
# Inbound back-pressure on a full FIFO
W 0 00000005 F 0
S A001
S B001
S A002
S B002
S A003
S B003
S A004
S B004
S A005
S B005
S A006
S B006
S A007
S B007
S A008
S B008
S A009
S B009
N 0
R 4 00000802 0
R 8 A001B001 0
N 1
R 8 A002B002 0
R 8 A003B003 0
R 8 A004B004 0
R 8 A005B005 0
R 8 A006B006 0
R 8 A007B007 0
R 8 A008B008 0
R 8 A009B009 0
R 4 00000001 0
# Count of completed words and its clear
R C 0000000F 0
W C 00000000 F 0
R C 00000000 0

/* tests/sdmacTb.sv */
//************************************************************
// Testbench for the SCSI DMA data path at the default
// FifoDepth of 8, which the values in the stimulus assume.
// Run it from the project root so the stimulus file opens.
// The run stops at the first mismatch or handshake timeout.
//************************************************************
`timescale 1ns/1ns

module sdmacTb;

    // Handshake waits give up after this many cycles
    localparam int TimeoutCycles = 200;

    logic                CLK;
    logic                rst;
    sdmacPkg::regAddr_t  awaddr;
    logic                awvalid;
    logic                awready;
    sdmacPkg::cpuWord_t  wdata;
    logic [3:0]          wstrb;
    logic                wvalid;
    logic                wready;
    sdmacPkg::axiResp_t  bresp;
    logic                bvalid;
    logic                bready;
    sdmacPkg::regAddr_t  araddr;
    logic                arvalid;
    logic                arready;
    sdmacPkg::cpuWord_t  rdata;
    sdmacPkg::axiResp_t  rresp;
    logic                rvalid;
    logic                rready;
    sdmacPkg::scsiHalf_t pdIn;
    logic                pdInValid;
    logic                pdInReady;
    sdmacPkg::scsiHalf_t pdOut;
    logic                pdOutValid;
    logic                pdOutReady;
    int                  seed;

    sdmacDatapath #(.FifoDepth(8)) uut (
        .CLK(CLK), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .pdIn(pdIn), .pdInValid(pdInValid), .pdInReady(pdInReady),
        .pdOut(pdOut), .pdOutValid(pdOutValid), .pdOutReady(pdOutReady)
    );

    // Period of 4 ns
    always #2 CLK = ~CLK;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkFieldCount(input int got, input int want);
        if (got != want) begin
            abortRun("A line of the stimulus file has missing or bad fields");
        end
    endtask

    // Tasks start and end 1 ns after a rising edge and sample at the falling edge
    task automatic writeReg(input sdmacPkg::regAddr_t addr, input sdmacPkg::cpuWord_t data,
                            input logic [3:0] strb, input sdmacPkg::axiResp_t expResp);
        int cycles;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        cycles  = 0;
        @(negedge CLK);
        while (!(awready && wready)) begin
            cycles = cycles + 1;
            if (cycles > TimeoutCycles) begin
                abortRun($sformatf("Write to 0x%h never saw awready and wready", addr));
            end
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        cycles  = 0;
        @(negedge CLK);
        while (!bvalid) begin
            cycles = cycles + 1;
            if (cycles > TimeoutCycles) begin
                abortRun($sformatf("Write to 0x%h never got a response", addr));
            end
            @(negedge CLK);
        end
        assert (bresp == expResp) else begin
            abortRun($sformatf("[ERROR] %0t ns: write to 0x%h answered %0d, expected %0d",
                               $time, addr, bresp, expResp));
        end
        @(posedge CLK);
        #1;
        bready = 1'b0;
    endtask

    task automatic readReg(input sdmacPkg::regAddr_t addr, input sdmacPkg::cpuWord_t expData,
                           input sdmacPkg::axiResp_t expResp);
        int cycles;
        araddr  = addr;
        arvalid = 1'b1;
        cycles  = 0;
        @(negedge CLK);
        while (!arready) begin
            cycles = cycles + 1;
            if (cycles > TimeoutCycles) begin
                abortRun($sformatf("Read of 0x%h never saw arready", addr));
            end
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        cycles  = 0;
        @(negedge CLK);
        while (!rvalid) begin
            cycles = cycles + 1;
            if (cycles > TimeoutCycles) begin
                abortRun($sformatf("Read of 0x%h never returned data", addr));
            end
            @(negedge CLK);
        end
        assert (rdata == expData && rresp == expResp) else begin
            abortRun($sformatf("[ERROR] %0t ns: read of 0x%h gave 0x%h resp %0d, expected 0x%h resp %0d",
                               $time, addr, rdata, rresp, expData, expResp));
        end
        @(posedge CLK);
        #1;
        rready = 1'b0;
    endtask

    // One half goes in on the edge where valid and ready are both high
    task automatic sendHalf(input sdmacPkg::scsiHalf_t half);
        int cycles;
        pdIn      = half;
        pdInValid = 1'b1;
        cycles    = 0;
        @(negedge CLK);
        while (!pdInReady) begin
            cycles = cycles + 1;
            if (cycles > TimeoutCycles) begin
                abortRun($sformatf("Half 0x%h was never accepted on pdIn", half));
            end
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
        pdInValid = 1'b0;
    endtask

    // Ready is random while waiting, so the packer also sees stalls
    task automatic expectHalf(input sdmacPkg::scsiHalf_t expHalf);
        int   cycles;
        int   rnd;
        logic accepted;
        cycles   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            rnd        = $random(seed);
            pdOutReady = rnd[0];
            @(negedge CLK);
            if (pdOutValid && pdOutReady) begin
                assert (pdOut == expHalf) else begin
                    abortRun($sformatf("[ERROR] %0t ns: pdOut gave 0x%h, expected 0x%h",
                                       $time, pdOut, expHalf));
                end
                accepted = 1'b1;
            end else begin
                cycles = cycles + 1;
                if (cycles > TimeoutCycles) begin
                    abortRun($sformatf("Half 0x%h never appeared on pdOut", expHalf));
                end
            end
            @(posedge CLK);
            #1;
        end
        // Nothing leaves the packer between expected halves
        pdOutReady = 1'b0;
    endtask

    task automatic checkInReady(input logic expReady);
        @(negedge CLK);
        assert (pdInReady == expReady) else begin
            abortRun($sformatf("[ERROR] %0t ns: pdInReady is %0b, expected %0b",
                               $time, pdInReady, expReady));
        end
        @(posedge CLK);
        #1;
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge CLK);
            #1;
        end
    endtask

    initial begin
        int          fd;
        int          n;
        logic        endOfFile;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] s;
        logic [31:0] r;
        logic [1023:0] line;

        CLK        = 1'b0;
        rst        = 1'b1;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        pdIn       = '0;
        pdInValid  = 1'b0;
        pdOutReady = 1'b0;
        seed       = 1623;
        endOfFile  = 1'b0;

        fd = $fopen("tests/sdmacStim.txt", "r");
        if (fd == 0) begin
            abortRun("Cannot open the stimulus file tests/sdmacStim.txt");
        end

        // Reset covers three rising edges
        repeat (3) @(posedge CLK);
        #1;
        rst = 1'b0;

        // Each line starts with a one-letter operation and hex fields follow
        while (!endOfFile) begin
            n = $fscanf(fd, " %c", op);
            if (n != 1) begin
                endOfFile = 1'b1;
            end else if (op == "#") begin
                n = $fgets(line, fd);
            end else if (op == "W") begin
                n = $fscanf(fd, " %h %h %h %h", a, d, s, r);
                checkFieldCount(n, 4);
                writeReg(a[3:0], d, s[3:0], r[1:0]);
            end else if (op == "R") begin
                n = $fscanf(fd, " %h %h %h", a, d, r);
                checkFieldCount(n, 3);
                readReg(a[3:0], d, r[1:0]);
            end else if (op == "S") begin
                n = $fscanf(fd, " %h", d);
                checkFieldCount(n, 1);
                sendHalf(d[15:0]);
            end else if (op == "E") begin
                n = $fscanf(fd, " %h", d);
                checkFieldCount(n, 1);
                expectHalf(d[15:0]);
            end else if (op == "N") begin
                n = $fscanf(fd, " %h", d);
                checkFieldCount(n, 1);
                checkInReady(d[0]);
            end else if (op == "I") begin
                n = $fscanf(fd, " %h", d);
                checkFieldCount(n, 1);
                idleCycles(int'(d));
            end else begin
                abortRun($sformatf("Unknown operation %c in the stimulus file", op));
            end
        end
        $fclose(fd);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* hdl/sdmacDatapath.sv */
//**********************************************************
// Top of the SCSI DMA data path on a single clock.
// The CPU reaches the FIFO through AXI4-Lite, the SCSI side
// through 16-bit valid/ready ports.
//**********************************************************
`timescale 1ns/1ns

module sdmacDatapath #(
    parameter int FifoDepth = 8
) (
    input  logic                CLK,
    input  logic                rst,
    input  sdmacPkg::regAddr_t  awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  sdmacPkg::cpuWord_t  wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output sdmacPkg::axiResp_t  bresp,
    output logic                bvalid,
    input  logic                bready,
    input  sdmacPkg::regAddr_t  araddr,
    input  logic                arvalid,
    output logic                arready,
    output sdmacPkg::cpuWord_t  rdata,
    output sdmacPkg::axiResp_t  rresp,
    output logic                rvalid,
    input  logic                rready,
    input  sdmacPkg::scsiHalf_t pdIn,
    input  logic                pdInValid,
    output logic                pdInReady,
    output sdmacPkg::scsiHalf_t pdOut,
    output logic                pdOutValid,
    input  logic                pdOutReady
);

    // FIFO traffic, each side drives only in its own direction
    sdmacPkg::cpuWord_t         cpuPushData;
    sdmacPkg::cpuWord_t         pkPushData;
    sdmacPkg::cpuWord_t         popData;
    logic                       cpuPush;
    logic                       cpuPop;
    logic                       pkPush;
    logic                       pkPop;
    logic                       flush;
    logic [$clog2(FifoDepth):0] fifoLevel;
    logic                       fifoEmpty;
    logic                       fifoFull;

    // Packer steering from the control register
    logic                       dir;
    logic                       swap;
    logic                       enable;
    logic                       wordDone;

    dmaRegs #(.FifoDepth(FifoDepth)) uRegs (
        .CLK(CLK), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .cpuPushData(cpuPushData), .cpuPush(cpuPush), .cpuPop(cpuPop), .flush(flush),
        .cpuPopData(popData), .fifoLevel(fifoLevel),
        .fifoEmpty(fifoEmpty), .fifoFull(fifoFull),
        .dir(dir), .swap(swap), .enable(enable), .wordDone(wordDone)
    );

    wordFifo #(.FifoDepth(FifoDepth)) uFifo (
        .CLK(CLK), .rst(rst), .flush(flush),
        .cpuPush(cpuPush), .cpuPushData(cpuPushData),
        .pkPush(pkPush), .pkPushData(pkPushData),
        .cpuPop(cpuPop), .pkPop(pkPop),
        .popData(popData), .level(fifoLevel), .empty(fifoEmpty), .full(fifoFull)
    );

    scsiPacker uPacker (
        .CLK(CLK), .rst(rst), .dir(dir), .swap(swap), .enable(enable), .flush(flush),
        .pdIn(pdIn), .pdInValid(pdInValid), .pdInReady(pdInReady),
        .pdOut(pdOut), .pdOutValid(pdOutValid), .pdOutReady(pdOutReady),
        .pkPush(pkPush), .pkPushData(pkPushData), .pkPop(pkPop),
        .popData(popData), .empty(fifoEmpty), .full(fifoFull),
        .wordDone(wordDone)
    );

endmodule

/* hdl/scsiPacker.sv */
//**********************************************************
// Packs SCSI halves into FIFO words and unpacks them again.
// dir and swap must stay constant while a word is in the
// packer; change them only when idle or together with flush.
//**********************************************************
`timescale 1ns/1ns

module scsiPacker (
    input  logic                CLK,
    input  logic                rst,
    input  logic                dir,
    input  logic                swap,
    input  logic                enable,
    input  logic                flush,
    input  sdmacPkg::scsiHalf_t pdIn,
    input  logic                pdInValid,
    output logic                pdInReady,
    output sdmacPkg::scsiHalf_t pdOut,
    output logic                pdOutValid,
    input  logic                pdOutReady,
    output logic                pkPush,
    output sdmacPkg::cpuWord_t  pkPushData,
    output logic                pkPop,
    input  sdmacPkg::cpuWord_t  popData,
    input  logic                empty,
    input  logic                full,
    output logic                wordDone
);

    sdmacPkg::packState_t state;
    sdmacPkg::scsiHalf_t  halfReg;
    sdmacPkg::cpuWord_t   wordReg;
    sdmacPkg::cpuWord_t   joined;
    logic                 inHs;
    logic                 outHs;

    assign inHs  = pdInValid && pdInReady;
    assign outHs = pdOutValid && pdOutReady;

    // With swap clear the first half is the high half of the word
    assign joined = swap ? {pdIn, halfReg} : {halfReg, pdIn};

    // Inbound stalls only in Drain, where a finished word waits for room
    assign pdInReady  = dir && enable && (state == sdmacPkg::Idle || state == sdmacPkg::HaveFirst);
    assign pdOutValid = !dir && state != sdmacPkg::Idle;

    // HaveFirst sends the high half unless swapped, Drain sends the other one
    assign pdOut = ((state == sdmacPkg::HaveFirst) != swap) ? wordReg[31:16] : wordReg[15:0];

    // Outbound pops from Idle, or while the last half leaves so words overlap
    always_comb begin
        pkPop = 1'b0;
        if (!dir && enable && !empty && !flush) begin
            pkPop = state == sdmacPkg::Idle || (state == sdmacPkg::Drain && outHs);
        end
    end

    always_comb begin
        pkPush     = 1'b0;
        pkPushData = '0;
        if (dir && !full && !flush) begin
            if (state == sdmacPkg::HaveFirst && inHs) begin
                // Second half goes straight into the FIFO on its accept edge
                pkPush     = 1'b1;
                pkPushData = joined;
            end else if (state == sdmacPkg::Drain) begin
                pkPush     = 1'b1;
                pkPushData = wordReg;
            end
        end
    end

    // A word is done when it enters the FIFO or its last half leaves
    assign wordDone = pkPush || (!dir && state == sdmacPkg::Drain && outHs);

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            state <= sdmacPkg::Idle;
        end else begin
            case (state)
                sdmacPkg::Idle: begin
                    if (inHs || pkPop) begin
                        state <= sdmacPkg::HaveFirst;
                    end
                end
                sdmacPkg::HaveFirst: begin
                    if (dir && inHs) begin
                        state <= full ? sdmacPkg::Drain : sdmacPkg::Idle;
                    end else if (!dir && outHs) begin
                        state <= sdmacPkg::Drain;
                    end
                end
                sdmacPkg::Drain: begin
                    if (dir && !full) begin
                        state <= sdmacPkg::Idle;
                    end else if (!dir && outHs) begin
                        state <= pkPop ? sdmacPkg::HaveFirst : sdmacPkg::Idle;
                    end
                end
                default: state <= sdmacPkg::Idle;
            endcase
        end
    end

    // The word register holds the outbound word or an inbound word held back
    always_ff @(posedge CLK) begin
        if (inHs && state == sdmacPkg::Idle) begin
            halfReg <= pdIn;
        end
        if (pkPop) begin
            wordReg <= popData;
        end else if (inHs && state == sdmacPkg::HaveFirst && full) begin
            wordReg <= joined;
        end
    end

    stallHold: assert property (@(posedge CLK) disable iff (rst || flush)
        pdOutValid && !pdOutReady |=> pdOutValid && $stable(pdOut));

endmodule

/* hdl/wordFifo.sv */
//**********************************************************
// Synchronous word FIFO with two push and two pop sources.
// FifoDepth must be a power of two and at least 2.
// Inactive sources must drive their data inputs to zero.
//**********************************************************
`timescale 1ns/1ns

module wordFifo #(
    parameter int FifoDepth = 8
) (
    input  logic                       CLK,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       cpuPush,
    input  sdmacPkg::cpuWord_t         cpuPushData,
    input  logic                       pkPush,
    input  sdmacPkg::cpuWord_t         pkPushData,
    input  logic                       cpuPop,
    input  logic                       pkPop,
    output sdmacPkg::cpuWord_t         popData,
    output logic [$clog2(FifoDepth):0] level,
    output logic                       empty,
    output logic                       full
);

    localparam int PtrW = $clog2(FifoDepth);

    sdmacPkg::cpuWord_t mem [FifoDepth];
    logic [PtrW-1:0]    wrPtr;
    logic [PtrW-1:0]    rdPtr;
    logic               anyPush;
    logic               anyPop;
    logic               doPush;
    logic               doPop;
    sdmacPkg::cpuWord_t pushData;

    // Only one direction is active, so the sources can simply be ORed
    assign anyPush  = cpuPush || pkPush;
    assign anyPop   = cpuPop || pkPop;
    assign pushData = cpuPushData | pkPushData;

    // Requests that would overrun or underrun are dropped
    assign doPush = anyPush && !full;
    assign doPop  = anyPop && !empty;

    assign popData = mem[rdPtr];
    assign empty   = level == '0;
    assign full    = level == (PtrW + 1)'(FifoDepth);

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end else begin
            // Pointers wrap naturally at the power-of-two depth
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    noPushFull: assert property (@(posedge CLK) disable iff (rst || flush) !(anyPush && full));
    noPopEmpty: assert property (@(posedge CLK) disable iff (rst || flush) !(anyPop && empty));
    oneSource:  assert property (@(posedge CLK) disable iff (rst) !(cpuPush && pkPush));

endmodule

/* hdl/dmaRegs.sv */
//**********************************************************
// AXI4-Lite register block of the DMA data path.
// One access per channel at a time; a new handshake waits
// until the previous response has been taken.
// The master must hold address and data stable while valid.
// Level is shown in STATUS[15:8], so FifoDepth is at most 128.
//**********************************************************
`timescale 1ns/1ns

module dmaRegs #(
    parameter int FifoDepth = 8
) (
    input  logic                         CLK,
    input  logic                         rst,
    input  sdmacPkg::regAddr_t           awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  sdmacPkg::cpuWord_t           wdata,
    input  logic [3:0]                   wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output sdmacPkg::axiResp_t           bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  sdmacPkg::regAddr_t           araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output sdmacPkg::cpuWord_t           rdata,
    output sdmacPkg::axiResp_t           rresp,
    output logic                         rvalid,
    input  logic                         rready,
    output sdmacPkg::cpuWord_t           cpuPushData,
    output logic                         cpuPush,
    output logic                         cpuPop,
    output logic                         flush,
    input  sdmacPkg::cpuWord_t           cpuPopData,
    input  logic [$clog2(FifoDepth):0]   fifoLevel,
    input  logic                         fifoEmpty,
    input  logic                         fifoFull,
    output logic                         dir,
    output logic                         swap,
    output logic                         enable,
    input  logic                         wordDone
);

    logic               wrHs;
    logic               rdHs;
    logic               ctrlWrite;
    logic               dataWrOk;
    logic               dataRdOk;
    logic [15:0]        count;
    sdmacPkg::cpuWord_t statusWord;
    sdmacPkg::cpuWord_t readValue;
    sdmacPkg::axiResp_t readResp;
    sdmacPkg::axiResp_t writeResp;

    // Address and data are taken together in a single handshake cycle
    assign wrHs = awready && awvalid && wready && wvalid;
    assign rdHs = arready && arvalid;

    // A control write without byte lane 0 is dropped but still answered OKAY
    assign ctrlWrite = wrHs && awaddr == sdmacPkg::RegCtrl && wstrb[0];

    // The data window only works in the direction that feeds or drains the CPU
    assign dataWrOk = !dir && !fifoFull && wstrb == 4'hF;
    assign dataRdOk = dir && !fifoEmpty;

    assign cpuPush     = wrHs && awaddr == sdmacPkg::RegData && dataWrOk;
    assign cpuPushData = cpuPush ? wdata : '0;
    assign cpuPop      = rdHs && araddr == sdmacPkg::RegData && dataRdOk;

    always_comb begin
        statusWord       = '0;
        statusWord[0]    = fifoEmpty;
        statusWord[1]    = fifoFull;
        statusWord[15:8] = 8'(fifoLevel);
    end

    always_comb begin
        case (awaddr)
            sdmacPkg::RegCtrl,
            sdmacPkg::RegStatus,
            sdmacPkg::RegCount: writeResp = sdmacPkg::RespOkay;
            sdmacPkg::RegData:  writeResp = dataWrOk ? sdmacPkg::RespOkay : sdmacPkg::RespSlvErr;
            default:            writeResp = sdmacPkg::RespSlvErr;
        endcase
    end

    always_comb begin
        readValue = '0;
        readResp  = sdmacPkg::RespOkay;
        case (araddr)
            // Flush always reads back as zero
            sdmacPkg::RegCtrl:   readValue = {29'b0, enable, swap, dir};
            sdmacPkg::RegStatus: readValue = statusWord;
            sdmacPkg::RegData: begin
                if (dataRdOk) begin
                    readValue = cpuPopData;
                end else begin
                    readResp = sdmacPkg::RespSlvErr;
                end
            end
            sdmacPkg::RegCount:  readValue = {16'b0, count};
            default:             readResp = sdmacPkg::RespSlvErr;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            dir     <= 1'b0;
            swap    <= 1'b0;
            enable  <= 1'b0;
            flush   <= 1'b0;
            count   <= '0;
        end else begin
            // Ready pulses for one cycle and stays low while a response waits
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;
            arready <= arvalid && !arready && !rvalid;

            if (wrHs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rdHs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            // Flush is a one-cycle pulse after the control write
            flush <= ctrlWrite && wdata[3];
            if (ctrlWrite) begin
                dir    <= wdata[0];
                swap   <= wdata[1];
                enable <= wdata[2];
            end

            // Clearing wins over a completion in the same cycle
            if (wrHs && awaddr == sdmacPkg::RegCount) begin
                count <= '0;
            end else if (wordDone) begin
                count <= count + 16'd1;
            end
        end
    end

    // Response payload is captured on the handshake edge
    always_ff @(posedge CLK) begin
        if (wrHs) begin
            bresp <= writeResp;
        end
        if (rdHs) begin
            rdata <= readValue;
            rresp <= readResp;
        end
    end

    // A pending response keeps both its valid and its payload until taken
    bHold: assert property (@(posedge CLK) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));
    rHold: assert property (@(posedge CLK) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

/* hdl/sdmacPkg.sv */
//**********************************************************
// Shared types and constants of the SCSI DMA data path.
// Register offsets are byte addresses inside a 16-byte
// window, so only the low four address bits are decoded.
//**********************************************************

package sdmacPkg;

    // One word on the CPU side and one transfer on the SCSI side
    typedef logic [31:0] cpuWord_t;
    typedef logic [15:0] scsiHalf_t;

    // Byte address of a register in the AXI4-Lite window
    typedef logic [3:0] regAddr_t;

    // AXI response codes used by the register block
    typedef logic [1:0] axiResp_t;

    localparam axiResp_t RespOkay   = 2'b00;
    localparam axiResp_t RespSlvErr = 2'b10;

    // Control has dir in bit 0, swap in bit 1, enable in bit 2 and a
    // self-clearing flush in bit 3
    localparam regAddr_t RegCtrl   = 4'h0;
    // Status has empty in bit 0, full in bit 1 and the level in bits 15:8
    localparam regAddr_t RegStatus = 4'h4;
    // Window onto the FIFO, pushed by writes and popped by reads
    localparam regAddr_t RegData   = 4'h8;
    // Completed word counter, any write clears it
    localparam regAddr_t RegCount  = 4'hC;

    // Idle waits for work, HaveFirst holds the first half of a word and
    // Drain holds the second half (outbound) or a word the full FIFO
    // could not yet take (inbound)
    typedef enum logic [1:0] {
        Idle,
        HaveFirst,
        Drain
    } packState_t;

endpackage
